// File: Makefile
# Verilator build and run for the memory address decoder testbench
VERILATOR ?= verilator
TOP       ?= mem_adec_tb
FILELIST  ?= mem_adec_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: dv/mem_adec_input.txt
# cmd value write io (hex): S size strap, C cpu page, B bus page,
# R refresh pulse, I idle cycles given by value
S 2 0 0
C 1 1 0
C 3 0 0
B 2 1 0
C 4 1 0
B 5 0 0
C 2 0 1
R 0 0 0
C 0 0 0
B 3 1 0
I 8 0 0
S 3 0 0
C 5 1 0
B 5 0 0
C 6 0 0
B e 1 0
C 9 1 0
B 4 0 0
R 0 0 0
C d 1 0
B 0 1 1
S 0 0 0
C 1 1 0
B 1 0 0
S 1 0 0
C 1 0 0
C 2 1 0
R 0 0 0
I 4 0 0

// File: dv/mem_adec_tb.sv
/*
  Testbench for the onboard memory address decoder.
  Reads size, request and refresh commands from dv/mem_adec_input.txt,
  drives them on the falling edge, keeps expected CPU, bus and off-board
  results in queues and checks every memory cycle and forward against them.
  Random back-pressure on mem_cyc_ready and ext_req_ready comes from an LFSR.
*/
module mem_adec_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_adec_pkg::*;

  localparam int wait_limit = 200;  // Cycles per wait

  logic     clk;
  logic     rst_n;
  msize_t   msize;
  mem_req_t cpu_req;
  logic     cpu_req_valid;
  logic     cpu_req_ready;
  mem_req_t bus_req;
  logic     bus_req_valid;
  logic     bus_req_ready;
  mem_req_t ext_req;
  logic     ext_req_valid;
  logic     ext_req_ready;
  mem_cyc_t mem_cyc;
  logic     mem_cyc_valid;
  logic     mem_cyc_ready;
  logic     refresh_pulse;

  mem_cyc_t cpu_cyc_q[$];  // Expected CPU cycles
  mem_cyc_t bus_cyc_q[$];  // Expected bus cycles
  mem_req_t ext_q[$];      // Expected off-board forwards
  mem_cyc_t exp_cyc;
  mem_req_t exp_ext;
  logic     cpu_taken;     // Set at the edge of a CPU transfer
  logic     bus_taken;
  logic     refresh_outstanding;
  int       refresh_expected;
  int       refresh_seen;
  logic [31:0] lfsr_q = 32'd98554;

  mem_adec_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR: %s expected 0x%0h got 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  // Onboard rule: not I/O, memory on, page below twice the strap
  function automatic logic is_onboard(input mem_req_t r, input msize_t s);
    return !r.io && (s != 2'd0) && (int'(r.page) < 2 * int'(s));
  endfunction

  function automatic mem_cyc_t make_cyc(input mem_req_t r, input cyc_src_e src);
    mem_cyc_t c;
    c.bank  = r.page[2:0];  // Low page bits
    c.write = r.write;
    c.src   = src;
    return c;
  endfunction

  // Next falling edge, retire finished handshakes, new back-pressure
  task automatic step();
    @(negedge clk);
    if (cpu_taken) begin
      cpu_req_valid = 1'b0;
      cpu_taken     = 1'b0;
    end
    if (bus_taken) begin
      bus_req_valid = 1'b0;
      bus_taken     = 1'b0;
    end
    refresh_pulse = 1'b0;  // Single cycle
    mem_cyc_ready = !(next_rand_bit() & next_rand_bit());  // Low one cycle in four
    ext_req_ready = !(next_rand_bit() & next_rand_bit());
  endtask

  function automatic logic all_idle();
    return !cpu_req_valid && !bus_req_valid && !refresh_outstanding &&
           cpu_cyc_q.size() == 0 && bus_cyc_q.size() == 0 && ext_q.size() == 0;
  endfunction

  task automatic wait_until_idle(input string what);
    int n;
    n = 0;
    while (!all_idle() && n < wait_limit) begin
      step();
      n++;
    end
    if (!all_idle()) begin
      $display("Timeout: %s did not complete", what);
      abort_run();
    end
  endtask

  task automatic issue_cpu(input mem_req_t r);
    int n;
    n = 0;
    while (cpu_req_valid && n < wait_limit) begin
      step();
      n++;
    end
    if (cpu_req_valid) begin
      $display("Timeout: CPU request was never accepted");
      abort_run();
    end else begin
      cpu_req       = r;
      cpu_req_valid = 1'b1;
      if (is_onboard(r, msize)) cpu_cyc_q.push_back(make_cyc(r, src_cpu));
      else ext_q.push_back(r);   // Forwarded unchanged
    end
  endtask

  task automatic issue_bus(input mem_req_t r);
    int n;
    n = 0;
    while (bus_req_valid && n < wait_limit) begin
      step();
      n++;
    end
    if (bus_req_valid) begin
      $display("Timeout: bus request was never accepted");
      abort_run();
    end else begin
      bus_req       = r;
      bus_req_valid = 1'b1;
      if (is_onboard(r, msize)) bus_cyc_q.push_back(make_cyc(r, src_bus));
    end   // Misses vanish
  endtask

  task automatic issue_refresh();
    int n;
    n = 0;
    while (refresh_outstanding && n < wait_limit) begin
      step();
      n++;
    end
    if (refresh_outstanding) begin
      $display("Timeout: earlier refresh cycle never appeared");
      abort_run();
    end else begin
      refresh_pulse       = 1'b1;
      refresh_outstanding = 1'b1;
      refresh_expected++;  // Nothing pending, so no merge
      step();
    end
  endtask

  task automatic run_line(input string line);
    logic [7:0] cmd;
    int val;
    int wr;
    int io_f;
    mem_req_t r;
    if ($sscanf(line, "%c %h %h %h", cmd, val, wr, io_f) != 4) begin
      $display("Malformed stimulus line: %s", line);
      abort_run();
    end else begin
      r.page  = page_t'(val);
      r.write = wr[0];
      r.io    = io_f[0];
      case (cmd)
        "S": begin
          wait_until_idle("traffic before a size change");
          step();  // Let a dropped bus miss leave its entry
          step();
          msize = msize_t'(val);
        end
        "C": issue_cpu(r);
        "B": issue_bus(r);
        "R": issue_refresh();
        "I": repeat (val) step();
        default: begin
          $display("Unknown stimulus command in line: %s", line);
          abort_run();
        end
      endcase
    end
  endtask

  // Handshakes seen at the rising edge, before the DUT registers update
  always @(posedge clk) begin
    if (rst_n) begin
      if (cpu_req_valid && cpu_req_ready) cpu_taken = 1'b1;
      if (bus_req_valid && bus_req_ready) bus_taken = 1'b1;
      if (ext_req_valid && ext_req_ready) begin
        if (ext_q.size() == 0) begin
          $display("Off-board forward appeared with none expected");
          abort_run();
        end else begin
          exp_ext = ext_q.pop_front();
          check_value("ext_req", 32'(exp_ext), 32'(ext_req));
        end
      end
      if (mem_cyc_valid && mem_cyc_ready) begin
        if (mem_cyc.src == src_cpu && cpu_cyc_q.size() != 0) begin
          exp_cyc = cpu_cyc_q.pop_front();
          check_value("mem_cyc", 32'(exp_cyc), 32'(mem_cyc));
        end else if (mem_cyc.src == src_bus && bus_cyc_q.size() != 0) begin
          exp_cyc = bus_cyc_q.pop_front();
          check_value("mem_cyc", 32'(exp_cyc), 32'(mem_cyc));
        end else if (mem_cyc.src == src_refresh && refresh_outstanding) begin
          exp_cyc.bank  = 3'd7;   // All bank lines high
          exp_cyc.write = 1'b0;
          exp_cyc.src   = src_refresh;
          check_value("mem_cyc", 32'(exp_cyc), 32'(mem_cyc));
          refresh_outstanding = 1'b0;
          refresh_seen++;
        end else begin
          $display("Memory cycle appeared that no request or refresh explains");
          abort_run();
        end
      end
    end
  end

  initial begin
    int    fd;
    int    rc;
    string line;
    rst_n = 1'b0;
    msize = 2'd0;
    cpu_req = '0;
    cpu_req_valid = 1'b0;
    bus_req = '0;
    bus_req_valid = 1'b0;
    ext_req_ready = 1'b1;
    mem_cyc_ready = 1'b1;
    refresh_pulse = 1'b0;
    cpu_taken = 1'b0;
    bus_taken = 1'b0;
    refresh_outstanding = 1'b0;
    refresh_expected = 0;
    refresh_seen = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // Idle state straight out of reset
    check_value("mem_cyc_valid", 32'(1'b0), 32'(mem_cyc_valid));
    check_value("ext_req_valid", 32'(1'b0), 32'(ext_req_valid));
    check_value("cpu_req_ready", 32'(1'b1), 32'(cpu_req_ready));
    check_value("bus_req_ready", 32'(1'b1), 32'(bus_req_ready));
    fd = $fopen("dv/mem_adec_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file dv/mem_adec_input.txt");
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != "#") run_line(line);
      end
      $fclose(fd);
      wait_until_idle("final drain of expected results");
      repeat (8) step();  // Room for stray outputs
      if (refresh_seen != refresh_expected || !all_idle()) begin
        $display("Refresh cycles seen %0d, expected %0d, or results left over",
                 refresh_seen, refresh_expected);
        abort_run();
      end else begin
        $display("Test completed successfully");
        $finish;
      end
    end
  end

endmodule

// File: logic/mem_adec_pkg.sv
/*
  Shared types for the onboard memory address decoder.
  Holds the page, bank and size widths, the request and memory-cycle
  structs and the enums for cycle ownership and decoder state.
  Modules import it with a wildcard inside the body.
*/
package mem_adec_pkg;

  typedef logic [3:0] page_t;   // Address bits 23..20, one 1 MB page
  typedef logic [2:0] bank_t;   // Onboard bank select
  typedef logic [1:0] msize_t;  // Size strap, 0 = off, n = 2n MB

  // All bank lines high on refresh
  localparam bank_t refresh_bank = 3'b111;

  // Request from the CPU or the external bus
  typedef struct packed {
    page_t page;
    logic  write;
    logic  io;     // I/O space, never onboard
  } mem_req_t;

  // Owner of a memory cycle
  typedef enum logic [1:0] {
    src_cpu     = 2'd0,
    src_bus     = 2'd1,
    src_refresh = 2'd2
  } cyc_src_e;

  // One cycle towards the memory array
  typedef struct packed {
    bank_t    bank;
    logic     write;
    cyc_src_e src;
  } mem_cyc_t;

  // Decoder entry
  typedef enum logic {
    dec_empty = 1'b0,
    dec_full  = 1'b1
  } dec_state_e;

endpackage

// File: logic/mem_adec_top.sv
/*
  Top level of the onboard memory address decoder.
  CPU and external bus requests are decoded against the size strap;
  hits are arbitrated with refresh into memory cycles, CPU misses go
  off-board on ext_req and bus misses are dropped.
*/
module mem_adec_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_adec_pkg::msize_t   msize,
  input  mem_adec_pkg::mem_req_t cpu_req,
  input  logic                   cpu_req_valid,
  output logic                   cpu_req_ready,
  input  mem_adec_pkg::mem_req_t bus_req,
  input  logic                   bus_req_valid,
  output logic                   bus_req_ready,
  output mem_adec_pkg::mem_req_t ext_req,
  output logic                   ext_req_valid,
  input  logic                   ext_req_ready,
  output mem_adec_pkg::mem_cyc_t mem_cyc,
  output logic                   mem_cyc_valid,
  input  logic                   mem_cyc_ready,
  input  logic                   refresh_pulse
);
  import mem_adec_pkg::*;

  logic  cpu_hit_valid;
  bank_t cpu_hit_bank;
  logic  cpu_hit_write;
  logic  cpu_grant;        // Ready for the CPU hit side
  logic  bus_hit_valid;
  bank_t bus_hit_bank;
  logic  bus_hit_write;
  logic  bus_grant;
  logic  bus_miss_ready;

  // Bus misses belong to another board
  assign bus_miss_ready = 1'b1;

  page_decoder cpu_dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .msize      (msize),
    .in_req     (cpu_req),
    .in_valid   (cpu_req_valid),
    .in_ready   (cpu_req_ready),
    .hit_valid  (cpu_hit_valid),
    .hit_bank   (cpu_hit_bank),
    .hit_write  (cpu_hit_write),
    .hit_ready  (cpu_grant),
    .miss_req   (ext_req),        // Off-board port
    .miss_valid (ext_req_valid),
    .miss_ready (ext_req_ready)
  );

  page_decoder bus_dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .msize      (msize),
    .in_req     (bus_req),
    .in_valid   (bus_req_valid),
    .in_ready   (bus_req_ready),
    .hit_valid  (bus_hit_valid),
    .hit_bank   (bus_hit_bank),
    .hit_write  (bus_hit_write),
    .hit_ready  (bus_grant),
    .miss_req   (),               // Dropped
    .miss_valid (),
    .miss_ready (bus_miss_ready)
  );

  mem_cycle_arb arb (
    .clk           (clk),
    .rst_n         (rst_n),
    .refresh_pulse (refresh_pulse),
    .cpu_hit_valid (cpu_hit_valid),
    .cpu_hit_bank  (cpu_hit_bank),
    .cpu_hit_write (cpu_hit_write),
    .cpu_grant     (cpu_grant),
    .bus_hit_valid (bus_hit_valid),
    .bus_hit_bank  (bus_hit_bank),
    .bus_hit_write (bus_hit_write),
    .bus_grant     (bus_grant),
    .mem_cyc       (mem_cyc),
    .mem_cyc_valid (mem_cyc_valid),
    .mem_cyc_ready (mem_cyc_ready)
  );

endmodule

// File: logic/mem_cycle_arb.sv
/*
  Memory cycle arbiter.
  Grants one source per cycle in the order refresh, bus, CPU and loads the
  winning cycle into a registered valid/ready output towards the array.
  Refresh pulses are latched until their cycle is loaded.
*/
module mem_cycle_arb (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  refresh_pulse,
  input  logic                  cpu_hit_valid,
  input  mem_adec_pkg::bank_t   cpu_hit_bank,
  input  logic                  cpu_hit_write,
  output logic                  cpu_grant,
  input  logic                  bus_hit_valid,
  input  mem_adec_pkg::bank_t   bus_hit_bank,
  input  logic                  bus_hit_write,
  output logic                  bus_grant,
  output mem_adec_pkg::mem_cyc_t mem_cyc,
  output logic                  mem_cyc_valid,
  input  logic                  mem_cyc_ready
);
  import mem_adec_pkg::*;

  logic     refresh_pend_q;  // Refresh waiting for a slot
  logic     cyc_valid_q;
  mem_cyc_t cyc_q;           // Output register
  mem_cyc_t cyc_d;
  logic     can_load;        // Output empty or draining
  logic     refresh_load;
  logic     load;

  assign can_load = !cyc_valid_q || mem_cyc_ready;

  // Fixed priority
  assign refresh_load = can_load && refresh_pend_q;
  assign bus_grant    = can_load && !refresh_pend_q && bus_hit_valid;
  assign cpu_grant    = can_load && !refresh_pend_q && !bus_hit_valid && cpu_hit_valid;
  assign load         = refresh_load || bus_grant || cpu_grant;

  // Build the cycle of the winner
  always_comb begin
    if (refresh_pend_q) begin
      cyc_d.bank  = refresh_bank;  // All lines high
      cyc_d.write = 1'b0;          // Refresh never writes
      cyc_d.src   = src_refresh;
    end else if (bus_hit_valid) begin
      cyc_d.bank  = bus_hit_bank;
      cyc_d.write = bus_hit_write;
      cyc_d.src   = src_bus;
    end else begin
      cyc_d.bank  = cpu_hit_bank;
      cyc_d.write = cpu_hit_write;
      cyc_d.src   = src_cpu;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refresh_pend_q <= 1'b0;
      cyc_valid_q    <= 1'b0;
    end else begin
      // New pulse sets the flag again and merges with one already pending
      refresh_pend_q <= refresh_pulse || (refresh_pend_q && !refresh_load);
      if (load) begin
        cyc_valid_q <= 1'b1;
      end else if (mem_cyc_ready) begin
        cyc_valid_q <= 1'b0;       // Taken with nothing behind it
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cyc_q <= cyc_d;
    end
  end

  assign mem_cyc       = cyc_q;
  assign mem_cyc_valid = cyc_valid_q;

  a_one_grant: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({cpu_grant, bus_grant})
  );

  // Stalled cycle stays on the output, no grant replaces it
  a_no_grant_stalled: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cyc_valid_q && !mem_cyc_ready) |=> (cyc_valid_q && $stable(cyc_q))
  );

endmodule

// File: logic/page_decoder.sv
/*
  One-entry request register with onboard page decode.
  A stored request goes out on the hit side (bank and write towards the
  arbiter) or on the miss side (request unchanged), never both.
  Used once for the CPU and once for the external bus.
*/
module page_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mem_adec_pkg::msize_t  msize,
  input  mem_adec_pkg::mem_req_t in_req,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic                  hit_valid,
  output mem_adec_pkg::bank_t   hit_bank,
  output logic                  hit_write,
  input  logic                  hit_ready,
  output mem_adec_pkg::mem_req_t miss_req,
  output logic                  miss_valid,
  input  logic                  miss_ready
);
  import mem_adec_pkg::*;

  dec_state_e state_q;
  mem_req_t   req_q;     // Held request
  logic       onboard;   // Stored page lives in onboard memory
  logic       leave;     // Entry handed over this cycle
  logic       accept;    // New request taken this cycle

  // Onboard when memory is on, not I/O, and page below twice the strap
  assign onboard = !req_q.io && (msize != '0) &&
                   (req_q.page < {1'b0, msize, 1'b0});

  assign hit_valid  = (state_q == dec_full) && onboard;
  assign miss_valid = (state_q == dec_full) && !onboard;
  assign hit_bank   = req_q.page[2:0];  // Low page bits pick the bank
  assign hit_write  = req_q.write;
  assign miss_req   = req_q;            // Forwarded as received

  assign leave  = (hit_valid && hit_ready) || (miss_valid && miss_ready);
  assign in_ready = (state_q == dec_empty) || leave;  // Full rate when draining
  assign accept = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= dec_empty;
    end else if (accept) begin
      state_q <= dec_full;
    end else if (leave) begin
      state_q <= dec_empty;
    end
  end

  // Request loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= in_req;
    end
  end

  // One side only
  a_hit_miss_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(hit_valid && miss_valid)
  );

  // Stalled hit keeps its side, bank and write until taken
  a_hit_stall_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (hit_valid && !hit_ready) |=> (hit_valid && $stable({hit_bank, hit_write}))
  );

  // Stalled miss keeps its side and request until taken
  a_miss_stall_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (miss_valid && !miss_ready) |=> (miss_valid && $stable(miss_req))
  );

endmodule

// File: mem_adec_top.f
logic/mem_adec_pkg.sv
logic/page_decoder.sv
logic/mem_cycle_arb.sv
logic/mem_adec_top.sv
dv/mem_adec_tb.sv
